// File: rtl/mem_bridge_params.svh
`ifndef MEM_BRIDGE_PARAMS_SVH
`define MEM_BRIDGE_PARAMS_SVH

//////////////////////////////
// bus widths
//////////////////////////////

`define MB_ADDR_W 32
`define MB_DATA_W 32
`define MB_ID_W 4

// burst length is beats minus one
`define MB_LEN_W 4

// one strobe bit per data byte
`define MB_STRB_W 4

`endif

// File: rtl/bus_pkg.sv
`include "mem_bridge_params.svh"

package bus_pkg;

	typedef logic [`MB_ID_W-1:0] axi_id_t;
	typedef logic [`MB_LEN_W-1:0] burst_len_t;
	typedef logic [`MB_STRB_W-1:0] strb_t;

	// read ids, one per source
	localparam axi_id_t ID_FETCH = 4'd0;
	localparam axi_id_t ID_LANE_1 = 4'd1;
	localparam axi_id_t ID_LANE_2 = 4'd2;

	// instruction pair is a two beat burst
	localparam burst_len_t LEN_PAIR = 4'd1;
	localparam burst_len_t LEN_SINGLE = 4'd0;

	typedef struct packed {
		axi_id_t id;
		logic [`MB_ADDR_W-1:0] addr;
		burst_len_t len;
	} ar_chan_t;

	typedef struct packed {
		logic [`MB_DATA_W-1:0] data;
		strb_t strb;
	} w_chan_t;

	typedef struct packed {
		axi_id_t id;
		logic [`MB_DATA_W-1:0] data;
	} r_beat_t;

endpackage

// File: rtl/lane_pkg.sv
`include "mem_bridge_params.svh"

package lane_pkg;

	typedef logic [`MB_ADDR_W-1:0] addr_t;
	typedef logic [`MB_DATA_W-1:0] word_t;

	typedef enum logic [1:0] {
		SIZE_BYTE,
		SIZE_HALF,
		SIZE_WORD
	} access_size_t;

	//////////////////////////////
	// lane side request
	//////////////////////////////

	// held as a level by the lane until it is served
	typedef struct packed {
		logic load_en;
		logic store_en;
		addr_t addr;
		access_size_t size;
		word_t store_data;
	} lane_req_t;

	// per access progress inside a tracker
	typedef enum logic [1:0] {
		REQ_IDLE,
		REQ_PENDING,
		REQ_DONE
	} req_state_t;

endpackage

// File: rtl/lane_request_tracker.sv
`timescale 1ns/1ps

`include "mem_bridge_params.svh"

module lane_request_tracker (
	input logic clk,
	input logic reset,
	input lane_pkg::lane_req_t lane_req,
	input logic load_done,
	input logic store_done,
	output logic load_pending,
	output logic store_pending,
	output logic lane_stall
);

	import lane_pkg::*;

	req_state_t load_state;
	req_state_t store_state;

	// shared step for the load and the store machine
	function automatic req_state_t step(
		input req_state_t state,
		input logic en,
		input logic done
	);
		req_state_t next;
		next = state;
		case (state)
			REQ_IDLE:
			begin
				// forwarded result can land before any bus traffic
				if (done)
					next = REQ_DONE;
				else if (en)
					next = REQ_PENDING;
			end
			REQ_PENDING:
			begin
				if (done)
					next = REQ_DONE;
			end
			default:
			begin
				// hold until the lane lets go of the enable
				if (!en)
					next = REQ_IDLE;
			end
		endcase
		return next;
	endfunction

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			load_state <= REQ_IDLE;
			store_state <= REQ_IDLE;
		end
		else
		begin
			load_state <= step(load_state, lane_req.load_en, load_done);
			store_state <= step(store_state, lane_req.store_en, store_done);
		end
	end

	assign load_pending = (load_state == REQ_PENDING);
	assign store_pending = (store_state == REQ_PENDING);

	// also stall in the cycle an enable is first seen
	assign lane_stall = load_pending || store_pending
		|| (lane_req.load_en && load_state == REQ_IDLE)
		|| (lane_req.store_en && store_state == REQ_IDLE);

	// write side only answers stores this lane has raised
	a_no_orphan_store_done: assert property (
		@(posedge clk) disable iff (!reset)
		!(store_done && store_state == REQ_IDLE)
	);

endmodule

// File: rtl/read_issue.sv
`timescale 1ns/1ps

`include "mem_bridge_params.svh"

module read_issue (
	input logic clk,
	input logic reset,
	input lane_pkg::addr_t pc,
	input logic fetch_pending,
	input logic load_pending_1,
	input logic load_pending_2,
	input lane_pkg::addr_t addr_1,
	input lane_pkg::addr_t addr_2,
	input logic load_done_1,
	input logic load_done_2,
	output bus_pkg::ar_chan_t ar,
	output logic arvalid,
	input logic arready
);

	import bus_pkg::*;

	logic issued_f;
	logic issued_1;
	logic issued_2;
	logic want_f;
	logic want_1;
	logic want_2;

	// one outstanding read per source
	assign want_f = fetch_pending && !issued_f;
	assign want_1 = load_pending_1 && !issued_1;
	assign want_2 = load_pending_2 && !issued_2;

	//////////////////////////////
	// read address issue
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			arvalid <= 1'b0;
			issued_f <= 1'b0;
			issued_1 <= 1'b0;
			issued_2 <= 1'b0;
		end
		else
		begin
			if (arvalid)
			begin
				if (arready)
					arvalid <= 1'b0;
			end
			else if (want_f)
			begin
				ar <= '{id: ID_FETCH, addr: pc, len: LEN_PAIR};
				arvalid <= 1'b1;
				issued_f <= 1'b1;
			end
			else if (want_1)
			begin
				ar <= '{id: ID_LANE_1, addr: addr_1, len: LEN_SINGLE};
				arvalid <= 1'b1;
				issued_1 <= 1'b1;
			end
			else if (want_2)
			begin
				ar <= '{id: ID_LANE_2, addr: addr_2, len: LEN_SINGLE};
				arvalid <= 1'b1;
				issued_2 <= 1'b1;
			end

			// released by the return side
			if (!fetch_pending)
				issued_f <= 1'b0;
			if (load_done_1)
				issued_1 <= 1'b0;
			if (load_done_2)
				issued_2 <= 1'b0;
		end
	end

	a_ar_stable: assert property (
		@(posedge clk) disable iff (!reset)
		arvalid && !arready |=> arvalid && $stable(ar)
	);

endmodule

// File: rtl/write_issue.sv
`timescale 1ns/1ps

`include "mem_bridge_params.svh"

module write_issue (
	input logic clk,
	input logic reset,
	input lane_pkg::lane_req_t lane_req_1,
	input lane_pkg::lane_req_t lane_req_2,
	input logic store_pending_1,
	input logic store_pending_2,
	output lane_pkg::addr_t awaddr,
	output logic awvalid,
	input logic awready,
	output bus_pkg::w_chan_t w,
	output logic wvalid,
	input logic wready,
	output logic store_done_1,
	output logic store_done_2
);

	import bus_pkg::*;
	import lane_pkg::*;

	typedef enum logic [1:0] {
		W_IDLE,
		W_ADDR,
		W_DATA,
		W_DONE
	} wr_state_t;

	wr_state_t state;
	logic from_lane_2;
	lane_req_t sel_req;

	// byte lanes touched by the access
	function automatic strb_t strobe_of(input access_size_t size, input logic [1:0] offset);
		strb_t strb;
		case (size)
			SIZE_BYTE: strb = strb_t'(1) << offset;
			SIZE_HALF: strb = offset[1] ? 4'b1100 : 4'b0011;
			default: strb = 4'b1111;
		endcase
		return strb;
	endfunction

	// lane 1 wins when both are waiting
	assign sel_req = store_pending_1 ? lane_req_1 : lane_req_2;

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			state <= W_IDLE;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			from_lane_2 <= 1'b0;
		end
		else
		begin
			case (state)
				W_IDLE:
				begin
					if (store_pending_1 || store_pending_2)
					begin
						awaddr <= sel_req.addr;
						w <= '{data: sel_req.store_data,
							strb: strobe_of(sel_req.size, sel_req.addr[1:0])};
						from_lane_2 <= !store_pending_1;
						awvalid <= 1'b1;
						state <= W_ADDR;
					end
				end
				W_ADDR:
				begin
					// data beat follows the address transfer
					if (awready)
					begin
						awvalid <= 1'b0;
						wvalid <= 1'b1;
						state <= W_DATA;
					end
				end
				W_DATA:
				begin
					if (wready)
					begin
						wvalid <= 1'b0;
						state <= W_DONE;
					end
				end
				default: state <= W_IDLE;
			endcase
		end
	end

	assign store_done_1 = (state == W_DONE) && !from_lane_2;
	assign store_done_2 = (state == W_DONE) && from_lane_2;

	a_aw_w_exclusive: assert property (
		@(posedge clk) disable iff (!reset)
		!(awvalid && wvalid)
	);

	a_w_held: assert property (
		@(posedge clk) disable iff (!reset)
		wvalid && !wready |=> wvalid
	);

endmodule

// File: rtl/read_return.sv
`timescale 1ns/1ps

`include "mem_bridge_params.svh"

module read_return (
	input logic clk,
	input logic reset,
	input logic fetch_start,
	input bus_pkg::r_beat_t r,
	input logic rvalid,
	input lane_pkg::lane_req_t lane_req_1,
	input lane_pkg::lane_req_t lane_req_2,
	output logic fetch_pending,
	output logic load_done_1,
	output logic load_done_2,
	output lane_pkg::word_t load_data_1,
	output lane_pkg::word_t load_data_2,
	output lane_pkg::word_t [1:2] inst_pair,
	output logic inst_pair_valid
);

	import bus_pkg::*;

	logic second_word;
	logic done_2_q;
	logic fwd_hit;
	logic fetch_beat;
	logic load_beat_1;
	logic load_beat_2;

	assign fetch_beat = rvalid && (r.id == ID_FETCH);
	assign load_beat_1 = rvalid && (r.id == ID_LANE_1);
	assign load_beat_2 = rvalid && (r.id == ID_LANE_2);

	// lane 2 reads what lane 1 is writing this cycle
	assign fwd_hit = lane_req_2.load_en && lane_req_1.store_en
		&& (lane_req_2.addr == lane_req_1.addr);

	assign load_done_2 = done_2_q || fwd_hit;

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			fetch_pending <= 1'b1;
			second_word <= 1'b0;
			inst_pair_valid <= 1'b0;
			load_done_1 <= 1'b0;
			done_2_q <= 1'b0;
		end
		else
		begin
			if (fetch_start)
				fetch_pending <= 1'b1;
			else if (fetch_beat && second_word)
				fetch_pending <= 1'b0;
			if (fetch_beat)
				second_word <= !second_word;
			inst_pair_valid <= fetch_beat && second_word;
			load_done_1 <= load_beat_1;
			done_2_q <= load_beat_2;
		end
	end

	//////////////////////////////
	// returned data
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (fetch_beat)
			inst_pair[second_word ? 2 : 1] <= r.data;
		if (load_beat_1)
			load_data_1 <= r.data;
		if (fwd_hit)
			load_data_2 <= lane_req_1.store_data;
		else if (load_beat_2)
			load_data_2 <= r.data;
	end

	// a forwarded load never goes out on the bus
	a_no_beat_on_fwd: assert property (
		@(posedge clk) disable iff (!reset)
		!(fwd_hit && load_beat_2)
	);

endmodule

// File: rtl/mem_bridge_top.sv
`timescale 1ns/1ps

`include "mem_bridge_params.svh"

module mem_bridge_top (
	input logic clk,
	input logic reset,
	input lane_pkg::lane_req_t lane_req_1,
	input lane_pkg::lane_req_t lane_req_2,
	input lane_pkg::addr_t pc,
	input logic fetch_start,
	output bus_pkg::ar_chan_t ar,
	output logic arvalid,
	input logic arready,
	input bus_pkg::r_beat_t r,
	input logic rvalid,
	output lane_pkg::addr_t awaddr,
	output logic awvalid,
	input logic awready,
	output bus_pkg::w_chan_t w,
	output logic wvalid,
	input logic wready,
	output lane_pkg::word_t load_data_1,
	output lane_pkg::word_t load_data_2,
	output lane_pkg::word_t [1:2] inst_pair,
	output logic inst_pair_valid,
	output logic stall
);

	logic fetch_pending;
	logic load_pending_1, load_pending_2;
	logic store_pending_1, store_pending_2;
	logic lane_stall_1, lane_stall_2;
	logic load_done_1, load_done_2;
	logic store_done_1, store_done_2;

	lane_request_tracker tracker_1_i (.clk, .reset, .lane_req(lane_req_1),
		.load_done(load_done_1), .store_done(store_done_1), .load_pending(load_pending_1),
		.store_pending(store_pending_1), .lane_stall(lane_stall_1));
	lane_request_tracker tracker_2_i (.clk, .reset, .lane_req(lane_req_2),
		.load_done(load_done_2), .store_done(store_done_2), .load_pending(load_pending_2),
		.store_pending(store_pending_2), .lane_stall(lane_stall_2));

	read_issue read_issue_i (.clk, .reset, .pc, .fetch_pending, .load_pending_1,
		.load_pending_2, .addr_1(lane_req_1.addr), .addr_2(lane_req_2.addr),
		.load_done_1, .load_done_2, .ar, .arvalid, .arready);

	write_issue write_issue_i (.clk, .reset, .lane_req_1, .lane_req_2, .store_pending_1,
		.store_pending_2, .awaddr, .awvalid, .awready, .w, .wvalid, .wready,
		.store_done_1, .store_done_2);

	read_return read_return_i (.clk, .reset, .fetch_start, .r, .rvalid, .lane_req_1,
		.lane_req_2, .fetch_pending, .load_done_1, .load_done_2, .load_data_1,
		.load_data_2, .inst_pair, .inst_pair_valid);

	// any open fetch or lane access holds the pipeline
	assign stall = fetch_pending || lane_stall_1 || lane_stall_2;

endmodule

// File: verification/mem_bridge_tb.sv
`timescale 1ns/1ps

module mem_bridge_tb;

	import bus_pkg::*;
	import lane_pkg::*;

	localparam int MAX_LINES = 32;
	localparam int COLS = 7;

	logic clk;
	logic reset;
	lane_req_t lane_req_1;
	lane_req_t lane_req_2;
	addr_t pc;
	logic fetch_start;
	ar_chan_t ar;
	logic arvalid;
	logic arready;
	r_beat_t r;
	logic rvalid;
	addr_t awaddr;
	logic awvalid;
	logic awready;
	w_chan_t w;
	logic wvalid;
	logic wready;
	word_t load_data_1;
	word_t load_data_2;
	word_t [1:2] inst_pair;
	logic inst_pair_valid;
	logic stall;

	logic [31:0] trace [0:MAX_LINES*COLS-1];
	integer seed;
	int n_lines;
	int cycles;
	int cycle_limit;
	int n_checks;
	int n_errors;

	// data the bus model hands back for each trace line
	word_t fetch_beat_1;
	word_t fetch_beat_2;
	word_t lane_beat_1;
	word_t lane_beat_2;

	// what the bus model saw
	ar_chan_t ar_log[$];
	r_beat_t beat_queue[$];
	addr_t aw_got;
	w_chan_t w_got;
	int w_count;
	logic ar_wait;
	logic aw_wait;
	logic w_wait;
	ar_chan_t ar_held;
	addr_t aw_held;
	w_chan_t w_held;

	// fetch beats alternate word 1 and word 2
	logic second_fetch_beat;
	logic pair_due;

	mem_bridge_top dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		n_errors++;
		$display("ERR %0t %s: got %0h, expected %0h", $time, name, got, exp);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		n_checks++;
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic check_strb(input string name, input strb_t got, input strb_t exp);
		n_checks++;
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		n_checks++;
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic check_id(input string name, input axi_id_t got, input axi_id_t exp);
		n_checks++;
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic check_len(input string name, input burst_len_t got, input burst_len_t exp);
		n_checks++;
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic expect_count(input string what, input int got, input int exp);
		n_checks++;
		if (got != exp)
		begin
			n_errors++;
			$display("%0t: saw %0d %s where %0d were expected", $time, got, what, exp);
		end
	endtask

	//////////////////////////////
	// bus model
	//////////////////////////////

	task automatic queue_beats(input ar_chan_t req);
		case (req.id)
			ID_FETCH:
			begin
				beat_queue.push_back(r_beat_t'{id: ID_FETCH, data: fetch_beat_1});
				beat_queue.push_back(r_beat_t'{id: ID_FETCH, data: fetch_beat_2});
			end
			ID_LANE_1: beat_queue.push_back(r_beat_t'{id: ID_LANE_1, data: lane_beat_1});
			default: beat_queue.push_back(r_beat_t'{id: req.id, data: lane_beat_2});
		endcase
	endtask

	always @(posedge clk)
	begin
		if (reset)
		begin
			// payload has to hold while valid waits for ready
			if (ar_wait)
			begin
				check_bit("arvalid", arvalid, 1'b1);
				check_addr("ar.addr", ar.addr, ar_held.addr);
				check_id("ar.id", ar.id, ar_held.id);
				check_len("ar.len", ar.len, ar_held.len);
			end
			if (aw_wait)
			begin
				check_bit("awvalid", awvalid, 1'b1);
				check_addr("awaddr", awaddr, aw_held);
			end
			if (w_wait)
			begin
				check_bit("wvalid", wvalid, 1'b1);
				check_word("w.data", w.data, w_held.data);
				check_strb("w.strb", w.strb, w_held.strb);
			end
			ar_wait = arvalid && !arready;
			aw_wait = awvalid && !awready;
			w_wait = wvalid && !wready;
			ar_held = ar;
			aw_held = awaddr;
			w_held = w;

			// pair valid follows the second fetch beat by one cycle
			check_bit("inst_pair_valid", inst_pair_valid, pair_due);
			pair_due = rvalid && (r.id == ID_FETCH) && second_fetch_beat;
			if (rvalid && (r.id == ID_FETCH))
				second_fetch_beat = !second_fetch_beat;

			if (arvalid && arready)
			begin
				ar_log.push_back(ar);
				queue_beats(ar);
			end
			if (awvalid && awready)
				aw_got = awaddr;
			if (wvalid && wready)
			begin
				w_got = w;
				w_count++;
			end

			arready <= ($random(seed) & 3) != 0;
			awready <= ($random(seed) & 3) != 0;
			wready <= ($random(seed) & 3) != 0;

			// one beat per cycle
			if (beat_queue.size() > 0)
			begin
				r <= beat_queue.pop_front();
				rvalid <= 1'b1;
			end
			else
				rvalid <= 1'b0;
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("timeout: the bridge did not finish within %0d cycles", cycle_limit);
			$display("checks: %0d, errors: %0d", n_checks, n_errors);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	//////////////////////////////
	// trace driven tests
	//////////////////////////////

	function automatic logic [31:0] trace_field(input int line, input int col);
		return trace[line*COLS+col];
	endfunction

	task automatic wait_not_stalled();
		@(posedge clk);
		while (stall)
			@(posedge clk);
	endtask

	task automatic release_lanes();
		lane_req_1 <= '0;
		lane_req_2 <= '0;
		repeat (3) @(posedge clk);
	endtask

	task automatic fetch_pair(input logic first, input addr_t addr, input word_t beat_1,
		input word_t beat_2);
		fetch_beat_1 = beat_1;
		fetch_beat_2 = beat_2;
		// the fetch after reset starts without a pulse
		if (!first)
		begin
			pc <= addr;
			fetch_start <= 1'b1;
			@(posedge clk);
			fetch_start <= 1'b0;
		end
		@(posedge clk);
		while (!inst_pair_valid)
			@(posedge clk);
		check_word("inst_pair[1]", inst_pair[1], beat_1);
		check_word("inst_pair[2]", inst_pair[2], beat_2);
		wait_not_stalled();
		expect_count("reads on ar", ar_log.size(), 1);
		check_id("ar.id", ar_log[0].id, ID_FETCH);
		check_len("ar.len", ar_log[0].len, LEN_PAIR);
		check_addr("ar.addr", ar_log[0].addr, addr);
	endtask

	task automatic single_load(input logic [31:0] lane, input addr_t addr, input word_t beat,
		input word_t exp);
		lane_req_t req;
		req = '{load_en: 1'b1, store_en: 1'b0, addr: addr, size: SIZE_WORD, store_data: '0};
		if (lane == 1)
		begin
			lane_beat_1 = beat;
			lane_req_1 <= req;
		end
		else
		begin
			lane_beat_2 = beat;
			lane_req_2 <= req;
		end
		wait_not_stalled();
		if (lane == 1)
			check_word("load_data_1", load_data_1, exp);
		else
			check_word("load_data_2", load_data_2, exp);
		release_lanes();
		expect_count("reads on ar", ar_log.size(), 1);
		check_id("ar.id", ar_log[0].id, axi_id_t'(lane));
		check_len("ar.len", ar_log[0].len, LEN_SINGLE);
		check_addr("ar.addr", ar_log[0].addr, addr);
	endtask

	task automatic dual_load(input addr_t addr_1, input addr_t addr_2, input word_t beat_1,
		input word_t beat_2);
		lane_beat_1 = beat_1;
		lane_beat_2 = beat_2;
		lane_req_1 <= '{load_en: 1'b1, store_en: 1'b0, addr: addr_1, size: SIZE_WORD,
			store_data: '0};
		lane_req_2 <= '{load_en: 1'b1, store_en: 1'b0, addr: addr_2, size: SIZE_WORD,
			store_data: '0};
		wait_not_stalled();
		check_word("load_data_1", load_data_1, beat_1);
		check_word("load_data_2", load_data_2, beat_2);
		release_lanes();
		// lane 1 goes out first
		expect_count("reads on ar", ar_log.size(), 2);
		check_id("first ar.id", ar_log[0].id, ID_LANE_1);
		check_addr("first ar.addr", ar_log[0].addr, addr_1);
		check_id("second ar.id", ar_log[1].id, ID_LANE_2);
		check_addr("second ar.addr", ar_log[1].addr, addr_2);
	endtask

	task automatic single_store(input logic [31:0] lane, input addr_t addr,
		input access_size_t size, input word_t data, input strb_t exp_strb);
		lane_req_t req;
		req = '{load_en: 1'b0, store_en: 1'b1, addr: addr, size: size, store_data: data};
		if (lane == 1)
			lane_req_1 <= req;
		else
			lane_req_2 <= req;
		wait_not_stalled();
		release_lanes();
		expect_count("write beats", w_count, 1);
		check_addr("awaddr", aw_got, addr);
		check_word("w.data", w_got.data, data);
		check_strb("w.strb", w_got.strb, exp_strb);
	endtask

	task automatic forwarded_load(input addr_t addr, input access_size_t size, input word_t data,
		input word_t exp);
		lane_req_1 <= '{load_en: 1'b0, store_en: 1'b1, addr: addr, size: size,
			store_data: data};
		lane_req_2 <= '{load_en: 1'b1, store_en: 1'b0, addr: addr, size: size,
			store_data: '0};
		wait_not_stalled();
		check_word("load_data_2", load_data_2, exp);
		release_lanes();
		// forwarded load never reaches the bus
		expect_count("reads on ar", ar_log.size(), 0);
		expect_count("write beats", w_count, 1);
		check_addr("awaddr", aw_got, addr);
		check_word("w.data", w_got.data, data);
	endtask

	task automatic apply_trace_line(input int i);
		logic [31:0] op;
		logic [31:0] lane;
		logic [31:0] raw_size;
		addr_t addr;
		word_t wdata;
		word_t rdata;
		word_t exp;
		op = trace_field(i, 0);
		lane = trace_field(i, 1);
		addr = trace_field(i, 2);
		raw_size = trace_field(i, 3);
		wdata = trace_field(i, 4);
		rdata = trace_field(i, 5);
		exp = trace_field(i, 6);
		ar_log.delete();
		w_count = 0;
		case (op)
			1: fetch_pair(i == 0, addr, rdata, exp);
			2: single_load(lane, addr, rdata, exp);
			3: single_store(lane, addr, access_size_t'(raw_size[1:0]), wdata, exp[3:0]);
			4: forwarded_load(addr, access_size_t'(raw_size[1:0]), wdata, exp);
			5: dual_load(addr, wdata, rdata, exp);
			default:
			begin
				n_errors++;
				$display("trace line %0d holds an unknown op %0h", i, op);
			end
		endcase
	endtask

	initial
	begin
		int i;
		seed = 32'had41_d01a;
		cycles = 0;
		cycle_limit = 0;
		n_checks = 0;
		n_errors = 0;
		w_count = 0;
		ar_wait = 1'b0;
		aw_wait = 1'b0;
		w_wait = 1'b0;
		second_fetch_beat = 1'b0;
		pair_due = 1'b0;
		reset = 1'b0;
		fetch_start = 1'b0;
		lane_req_1 = '0;
		lane_req_2 = '0;
		arready = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		r = '0;
		rvalid = 1'b0;

		$readmemh("verification/mem_bridge_trace.hex", trace);
		n_lines = 0;
		while (n_lines < MAX_LINES && trace_field(n_lines, 0) != 0)
			n_lines++;
		cycle_limit = 64 * n_lines + 100;
		// first line is the fetch that follows reset
		pc = trace_field(0, 2);

		repeat (4) @(posedge clk);
		check_bit("arvalid", arvalid, 1'b0);
		check_bit("awvalid", awvalid, 1'b0);
		check_bit("wvalid", wvalid, 1'b0);
		check_bit("stall", stall, 1'b1);
		reset <= 1'b1;

		for (i = 0; i < n_lines; i++)
			apply_trace_line(i);

		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: list.f
+incdir+rtl
rtl/bus_pkg.sv
rtl/lane_pkg.sv
rtl/lane_request_tracker.sv
rtl/read_issue.sv
rtl/write_issue.sv
rtl/read_return.sv
rtl/mem_bridge_top.sv
verification/mem_bridge_tb.sv

// File: run.sh
#!/bin/sh
# build the memory bridge testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module mem_bridge_tb -o mem_bridge_sim

out=$(./obj_dir/mem_bridge_sim)
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
	exit 0
fi
exit 1

// File: verification/mem_bridge_trace.hex
// op lane addr size wdata rdata expect, one hex word each, op 0 ends the trace
// op 1 fetch, 2 load, 3 store, 4 forwarded store and load, 5 load on both lanes
1 0 00001000 0 00000000 24020001 24030002
2 1 00002000 2 00000000 cafe0001 cafe0001
2 2 00002004 2 00000000 beef0002 beef0002
3 1 00003000 0 000000a5 00000000 00000001
3 1 00003001 0 0000a500 00000000 00000002
3 2 00003002 0 00a50000 00000000 00000004
3 2 00003003 0 a5000000 00000000 00000008
3 1 00003000 1 00001234 00000000 00000003
3 2 00003002 1 56780000 00000000 0000000c
3 1 00003004 2 deadbeef 00000000 0000000f
5 0 00004000 2 00004010 11112222 33334444
4 0 00005000 2 0badf00d 00000000 0badf00d
1 0 00001008 0 00000000 8c220000 ac230004
3 2 00003008 2 01234567 00000000 0000000f
3 1 00003006 1 9abc0000 00000000 0000000c
3 2 00003005 0 00007700 00000000 00000002
5 0 00004020 2 00004024 55556666 77778888
4 0 00005004 0 13579bdf 00000000 13579bdf
2 1 00002008 2 00000000 a1a1a1a1 a1a1a1a1
2 2 0000200c 2 00000000 5a5a0000 5a5a0000
1 0 00001010 0 00000000 00430820 00851020
0 0 00000000 0 00000000 00000000 00000000
